//--- sources.f
+incdir+.
modem_rx_pkg.sv
deframer_if.sv
spi_regs.sv
lvds_deframer.sv
rx_sample_buffer.sv
smi_reader.sv
modem_rx_top.sv
modem_rx_chk.sv
tb_modem_rx.sv

//--- tb_modem_rx.sv
`timescale 1ns/1ns
`include "modem_rx_settings.svh"

module tb_modem_rx import modem_rx_pkg::*; ();

  localparam int LP_REQ_TIMEOUT = 100;            // Cycles to wait for an SMI request
  localparam int LP_FRAME_CYC   = 25;             // 16 pairs, idle, longest gap
  localparam int LP_SPI_CYC     = 176;            // 16 bits at about 10 clocks each
  localparam int LP_SMI_CYC     = 60;             // Four strobes plus request wait
  localparam int LP_N_FRAMES    = 35;
  localparam int LP_N_SPI       = 16;
  localparam int LP_N_SMI       = 32;
  localparam int LP_WD_CYC      = LP_N_FRAMES * LP_FRAME_CYC + LP_N_SPI * LP_SPI_CYC +
                                  LP_N_SMI * LP_SMI_CYC + 500;
  localparam logic [1:0] LP_MASK  = `MRX_INVERT_MASK;
  localparam logic [1:0] LP_INV09 = {2{LP_MASK[0]}};   // Pin polarity per band
  localparam logic [1:0] LP_INV24 = {2{LP_MASK[1]}};

  logic       glob_clock = 1'b0;
  logic       rst_b;
  logic [1:0] iq_rx_09;
  logic [1:0] iq_rx_24;
  logic       sck;
  logic       mosi;
  logic       ss;
  logic       miso;
  logic       smi_a2;
  logic       smi_soe_se;
  logic [7:0] smi_data;
  logic       smi_data_oe;
  logic       smi_read_req;
  int         seed = 21;
  string      test_name = "reset";
  iq_word_u   exp_q [$];                          // Words the host should see
  iq_word_u   got_q [$];                          // Words read over SMI

  always #5 glob_clock = ~glob_clock;             // 100 MHz

  modem_rx_top i_dut (
    .i_glob_clock   (glob_clock),
    .i_rst_b        (rst_b),
    .i_iq_rx_09     (iq_rx_09),
    .i_iq_rx_24     (iq_rx_24),
    .i_sck          (sck),
    .i_mosi         (mosi),
    .i_ss           (ss),
    .o_miso         (miso),
    .i_smi_a2       (smi_a2),
    .i_smi_soe_se   (smi_soe_se),
    .o_smi_data     (smi_data),
    .o_smi_data_oe  (smi_data_oe),
    .o_smi_read_req (smi_read_req)
  );

  bind modem_rx_top modem_rx_chk u_chk (
    .i_glob_clock   (i_glob_clock),
    .i_rst_b        (i_rst_b),
    .i_smi_a2       (i_smi_a2),
    .i_smi_data_oe  (o_smi_data_oe),
    .i_smi_read_req (o_smi_read_req),
    .i_empty        (w_empty),
    .i_valid        ({df_bus[1].word_valid, df_bus[0].word_valid}),
    .i_ss           (i_ss),
    .i_miso         (o_miso)
  );

  // ====================================================================
  // Reference model and compare tasks
  // ====================================================================
  function automatic iq_word_u ref_word(input logic [13:0] i_val, input logic [13:0] q_val);
    iq_word_u w;
    w.fields.i_sync = 2'b10;                      // I sync leads the frame
    w.fields.i_data = i_val;
    w.fields.q_sync = 2'b01;
    w.fields.q_data = q_val;
    return w;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s: expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s: expected 0x%02h actual 0x%02h", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input iq_word_u exp, input iq_word_u act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s: expected 0x%08h actual 0x%08h", name, exp.raw, act.raw));
    end
  endtask

  // ====================================================================
  // Bus tasks
  // ====================================================================
  task automatic spi_xfer(input logic wr, input logic [4:0] addr, input logic [7:0] wdata,
                          output logic [7:0] rdata);
    logic [15:0] tx;
    tx    = {wr, 2'b00, addr, wdata};
    rdata = 8'h00;
    @(posedge glob_clock);
    ss <= 1'b0;
    for (int b = 15; b >= 0; b--) begin
      @(posedge glob_clock);
      mosi <= tx[b];                              // Mode 0 wants data ahead of the rising edge
      repeat (3) @(posedge glob_clock);
      @(negedge glob_clock);
      if (b < 8) begin
        rdata = {rdata[6:0], miso};               // Read byte comes MSB first
      end
      @(posedge glob_clock);
      sck <= 1'b1;
      repeat (4) @(posedge glob_clock);
      sck <= 1'b0;
    end
    repeat (4) @(posedge glob_clock);
    ss <= 1'b1;
    repeat (4) @(posedge glob_clock);
  endtask

  // One frame on each pair followed by a random idle gap
  task automatic drive_frames(input iq_word_u w09, input iq_word_u w24);
    int gap;
    for (int k = 0; k < 16; k++) begin
      @(posedge glob_clock);
      iq_rx_09 <= w09.raw[31-2*k -: 2] ^ LP_INV09;
      iq_rx_24 <= w24.raw[31-2*k -: 2] ^ LP_INV24;
    end
    gap = $random(seed) & 7;
    @(posedge glob_clock);
    iq_rx_09 <= LP_INV09;                         // Idle reads as 00 and never as I sync
    iq_rx_24 <= LP_INV24;
    repeat (gap) @(posedge glob_clock);
  endtask

  task automatic send_random(input int n, input band_t band, input int n_keep);
    logic [31:0] r09;
    logic [31:0] r24;
    iq_word_u    w09;
    iq_word_u    w24;
    for (int j = 0; j < n; j++) begin
      r09 = $random(seed);
      r24 = $random(seed);
      w09 = ref_word(r09[13:0], r09[29:16]);
      w24 = ref_word(r24[13:0], r24[29:16]);
      if (j < n_keep) begin
        exp_q.push_back((band == BAND_24) ? w24 : w09);  // Other band dropped
      end
      drive_frames(w09, w24);
    end
  endtask

  task automatic wait_req();
    int n;
    n = 0;
    @(negedge glob_clock);
    while (!smi_read_req && n < LP_REQ_TIMEOUT) begin
      @(negedge glob_clock);
      n++;
    end
    if (!smi_read_req) begin
      fail_run($sformatf("SMI read request did not rise within %0d cycles in %s",
                         LP_REQ_TIMEOUT, test_name));
    end
  endtask

  task automatic read_word();
    logic [31:0] acc;
    iq_word_u    w;
    wait_req();
    acc = '0;
    for (int b = 0; b < 4; b++) begin
      @(posedge glob_clock);
      smi_soe_se <= 1'b0;
      repeat (2) @(posedge glob_clock);
      @(negedge glob_clock);
      acc = {acc[23:0], smi_data};                // Top byte comes first
      check_bit("SMI output enable in strobe", 1'b1, smi_data_oe);
      @(posedge glob_clock);
      smi_soe_se <= 1'b1;
      @(negedge glob_clock);
      check_bit("SMI output enable after strobe", 1'b0, smi_data_oe);
      repeat (6) @(posedge glob_clock);           // Sync, advance, empty update
    end
    w.raw = acc;
    got_q.push_back(w);
  endtask

  task automatic read_words(input int n);
    for (int j = 0; j < n; j++) begin
      read_word();
    end
  endtask

  // ====================================================================
  // Compare, assertion monitor, watchdog
  // ====================================================================
  always @(negedge glob_clock) begin
    if (got_q.size() > 0) begin
      if (exp_q.size() == 0) begin
        fail_run($sformatf("Word 0x%08h read over SMI in %s with none expected",
                           got_q[0].raw, test_name));
      end else begin
        check_word(test_name, exp_q.pop_front(), got_q.pop_front());
      end
    end
  end

  always @(negedge glob_clock) begin
    if (i_dut.u_chk.assert_fails != 0) begin
      fail_run($sformatf("A bound protocol assertion failed in %s", test_name));
    end
  end

  initial begin
    #(LP_WD_CYC * 10);
    fail_run($sformatf("Watchdog expired after %0d cycles in %s", LP_WD_CYC, test_name));
  end

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial begin
    logic [7:0]  rd;
    logic [7:0]  err0;
    logic [31:0] rnd;
    iq_word_u    bad;
    iq_word_u    good;
    rst_b      <= 1'b0;
    iq_rx_09   <= LP_INV09;
    iq_rx_24   <= LP_INV24;
    sck        <= 1'b0;
    mosi       <= 1'b0;
    ss         <= 1'b1;
    smi_a2     <= 1'b0;
    smi_soe_se <= 1'b1;                           // Strobe idles high
    repeat (3) @(posedge glob_clock);
    rst_b      <= 1'b1;
    smi_soe_se <= 1'b0;                           // Strobe while A2 is still low
    repeat (2) @(posedge glob_clock);

    test_name = "SMI strobe with A2 low";
    @(negedge glob_clock);
    check_bit(test_name, 1'b0, smi_data_oe);
    @(posedge glob_clock);
    smi_soe_se <= 1'b1;
    repeat (4) @(posedge glob_clock);
    smi_a2 <= 1'b1;                               // RX direction from here on
    repeat (2) @(posedge glob_clock);

    test_name = "version read";
    spi_xfer(1'b0, `MRX_REG_VERSION, 8'h00, rd);
    check_byte(test_name, 8'h5A, rd);
    test_name = "control after reset";
    spi_xfer(1'b0, `MRX_REG_CTRL, 8'h00, rd);
    check_byte(test_name, 8'h00, rd);

    test_name = "control write";
    spi_xfer(1'b1, `MRX_REG_CTRL, 8'h02, rd);     // Enable, band 900
    spi_xfer(1'b0, `MRX_REG_CTRL, 8'h00, rd);
    check_byte(test_name, 8'h02, rd);

    test_name = "band 900 frames";
    send_random(8, BAND_09, 8);
    read_words(8);

    test_name = "band 2.4 inverted frames";
    spi_xfer(1'b1, `MRX_REG_CTRL, 8'h03, rd);     // Enable, band 2.4
    send_random(4, BAND_24, 4);
    read_words(4);

    test_name = "bad Q sync";
    spi_xfer(1'b1, `MRX_REG_CTRL, 8'h02, rd);     // Control write clears the count
    spi_xfer(1'b0, `MRX_REG_ERRCNT, 8'h00, err0);
    check_byte("sync error count cleared", 8'h00, err0);
    rnd  = $random(seed);
    bad  = ref_word(rnd[13:0], rnd[29:16]);
    bad.fields.q_sync = 2'b11;                    // Broken Q sync
    rnd  = $random(seed);
    good = ref_word(rnd[13:0], rnd[29:16]);
    exp_q.push_back(good);
    drive_frames(bad, good);                      // 2.4 pair stays clean
    drive_frames(good, good);
    read_words(1);
    spi_xfer(1'b0, `MRX_REG_ERRCNT, 8'h00, rd);
    check_byte("sync error count", 8'h01, rd);
    spi_xfer(1'b0, `MRX_REG_STATUS, 8'h00, rd);
    check_byte("empty after bad frame", 8'h01, rd & 8'h01);

    test_name = "reception disabled";
    spi_xfer(1'b1, `MRX_REG_CTRL, 8'h00, rd);
    send_random(1, BAND_09, 0);
    spi_xfer(1'b0, `MRX_REG_STATUS, 8'h00, rd);
    check_byte(test_name, 8'h01, rd & 8'h07);     // Empty, not full, no overflow

    test_name = "FIFO overflow";
    spi_xfer(1'b1, `MRX_REG_CTRL, 8'h02, rd);
    send_random(20, BAND_09, `MRX_FIFO_DEPTH);    // Last four dropped
    spi_xfer(1'b0, `MRX_REG_STATUS, 8'h00, rd);
    check_byte(test_name, 8'h06, rd & 8'h07);     // Full and overflow
    read_words(`MRX_FIFO_DEPTH);
    spi_xfer(1'b0, `MRX_REG_STATUS, 8'h00, rd);
    check_byte("overflow after drain", 8'h05, rd & 8'h07);  // Overflow sticks while empty

    repeat (4) @(posedge glob_clock);
    if (exp_q.size() != 0 || got_q.size() != 0) begin
      fail_run($sformatf("%0d expected words never read over SMI", exp_q.size()));
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- modem_rx_chk.sv
`timescale 1ns/1ns
`include "modem_rx_settings.svh"

module modem_rx_chk (
  input  logic                   i_glob_clock,
  input  logic                   i_rst_b,
  input  logic                   i_smi_a2,
  input  logic                   i_smi_data_oe,
  input  logic                   i_smi_read_req,
  input  logic                   i_empty,        // Host side FIFO empty
  input  logic [`MRX_NUM_CH-1:0] i_valid,        // Deframer word strobes
  input  logic                   i_ss,
  input  logic                   i_miso
);

  int assert_fails = 0;                          // Failed assertion count

  // ====================================================================
  // SMI bus rules
  // ====================================================================
  a_oe_needs_a2 : assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    !i_smi_a2 |-> !i_smi_data_oe)
    else begin
      $error("SMI data bus driven while A2 is low");
      assert_fails++;
    end

  // Empty FIFO and no new word means no request two cycles on
  a_req_idle : assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    (!(|i_valid) ##1 i_empty) |=> !i_smi_read_req)
    else begin
      $error("SMI read request raised with no word in the FIFO");
      assert_fails++;
    end

  // SPI output quiet while deselected
  a_miso_quiet : assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    i_ss |-> !i_miso)
    else begin
      $error("MISO high while slave select is high");
      assert_fails++;
    end

endmodule

//--- modem_rx_top.sv
`timescale 1ns/1ns
`include "modem_rx_settings.svh"

module modem_rx_top import modem_rx_pkg::*; (
  input  logic       i_glob_clock,
  input  logic       i_rst_b,
  // LVDS sample pairs
  input  logic [1:0] i_iq_rx_09,
  input  logic [1:0] i_iq_rx_24,
  // SPI host port
  input  logic       i_sck,
  input  logic       i_mosi,
  input  logic       i_ss,
  output logic       o_miso,
  // SMI host port
  input  logic       i_smi_a2,
  input  logic       i_smi_soe_se,
  output logic [7:0] o_smi_data,
  output logic       o_smi_data_oe,
  output logic       o_smi_read_req
);

  localparam logic [`MRX_NUM_CH-1:0] LP_INVERT = `MRX_INVERT_MASK;

  logic [1:0] w_pair [`MRX_NUM_CH];
  rx_ctrl_t   w_ctrl;
  logic       w_ovf_clear;
  logic [7:0] w_status;
  logic [7:0] w_err_count;
  logic       w_empty;
  iq_word_u   w_head;
  logic       w_pop;

  deframer_if df_bus [`MRX_NUM_CH] ();  // One link per band

  assign w_pair[0] = i_iq_rx_09;        // BAND_09
  assign w_pair[1] = i_iq_rx_24;        // BAND_24

  spi_regs u_spi_regs (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_sck        (i_sck),
    .i_mosi       (i_mosi),
    .i_ss         (i_ss),
    .o_miso       (o_miso),
    .o_ctrl       (w_ctrl),
    .o_ovf_clear  (w_ovf_clear),
    .i_status     (w_status),
    .i_err_count  (w_err_count)
  );

  generate
    for (genvar c = 0; c < `MRX_NUM_CH; c++) begin : g_deframer
      lvds_deframer #(
        .P_INVERT (LP_INVERT[c])
      ) u_deframer (
        .i_glob_clock (i_glob_clock),
        .i_rst_b      (i_rst_b),
        .i_pair       (w_pair[c]),
        .o_df         (df_bus[c])
      );
    end
  endgenerate

  rx_sample_buffer u_buffer (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_df         (df_bus),
    .i_ctrl       (w_ctrl),
    .i_ovf_clear  (w_ovf_clear),
    .o_empty      (w_empty),
    .o_head       (w_head),
    .i_pop        (w_pop),
    .o_status     (w_status),
    .o_err_count  (w_err_count)
  );

  smi_reader u_smi_reader (
    .i_glob_clock   (i_glob_clock),
    .i_rst_b        (i_rst_b),
    .i_smi_a2       (i_smi_a2),
    .i_smi_soe_se   (i_smi_soe_se),
    .i_empty        (w_empty),
    .i_head         (w_head),
    .o_pop          (w_pop),
    .o_smi_data     (o_smi_data),
    .o_smi_data_oe  (o_smi_data_oe),
    .o_smi_read_req (o_smi_read_req)
  );

endmodule

//--- smi_reader.sv
`timescale 1ns/1ns

module smi_reader import modem_rx_pkg::*; (
  input  logic       i_glob_clock,
  input  logic       i_rst_b,
  input  logic       i_smi_a2,         // High selects RX direction
  input  logic       i_smi_soe_se,     // Read strobe, active low
  input  logic       i_empty,
  input  iq_word_u   i_head,
  output logic       o_pop,
  output logic [7:0] o_smi_data,
  output logic       o_smi_data_oe,
  output logic       o_smi_read_req
);

  logic [2:0] r_soe_sync;              // Two sync flops plus edge history
  logic       w_strobe_rise;
  logic       w_advance;
  logic [1:0] r_byte_idx;
  logic [1:0] w_byte_sel;

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_soe_sync <= 3'b111;            // Strobe idles high
      r_byte_idx <= 2'd0;
    end else begin
      r_soe_sync <= {r_soe_sync[1:0], i_smi_soe_se};
      if (w_advance) begin
        r_byte_idx <= r_byte_idx + 2'd1;  // Wraps to 0 on the pop
      end
    end
  end

  // End of a read strobe moves to the next byte
  assign w_strobe_rise = r_soe_sync[1] & ~r_soe_sync[2];
  assign w_advance     = w_strobe_rise & i_smi_a2 & ~i_empty;
  assign o_pop         = w_advance & (r_byte_idx == 2'd3);  // Last byte done

  // Byte 0 is the top byte of the word
  assign w_byte_sel = ~r_byte_idx;
  assign o_smi_data = i_head.raw[{w_byte_sel, 3'b000} +: 8];

  assign o_smi_data_oe  = i_smi_a2 & ~i_smi_soe_se;
  assign o_smi_read_req = i_smi_a2 & ~i_empty;  // DMA request toward the host

endmodule

//--- rx_sample_buffer.sv
`timescale 1ns/1ns
`include "modem_rx_settings.svh"

module rx_sample_buffer import modem_rx_pkg::*; (
  input  logic       i_glob_clock,
  input  logic       i_rst_b,
  deframer_if.sink   i_df [`MRX_NUM_CH],
  input  rx_ctrl_t   i_ctrl,
  input  logic       i_ovf_clear,
  output logic       o_empty,
  output iq_word_u   o_head,
  input  logic       i_pop,
  output logic [7:0] o_status,
  output logic [7:0] o_err_count
);

  localparam int LP_AW = $clog2(`MRX_FIFO_DEPTH);

  logic [`MRX_NUM_CH-1:0] w_valid;
  logic [`MRX_NUM_CH-1:0] w_locked;
  logic [`MRX_NUM_CH-1:0] w_err;
  iq_word_u               w_word [`MRX_NUM_CH];
  iq_word_u               r_mem [`MRX_FIFO_DEPTH];
  logic [LP_AW:0]         r_wr_ptr;    // Extra bit tells full from empty
  logic [LP_AW:0]         r_rd_ptr;
  logic                   w_full;
  logic                   w_empty;
  logic                   w_sel_valid;
  logic                   w_push;
  logic                   w_pop;
  logic                   r_empty;
  logic                   r_ovf;
  logic [7:0]             r_err_count;
  logic [8:0]             w_err_sum;

  // Flatten the link array so the band select can index it
  for (genvar c = 0; c < `MRX_NUM_CH; c++) begin : g_link
    assign w_valid[c]  = i_df[c].word_valid;
    assign w_word[c]   = i_df[c].word;
    assign w_locked[c] = i_df[c].locked;
    assign w_err[c]    = i_df[c].sync_err;
  end

  // ====================================================================
  // Sample FIFO
  // ====================================================================
  assign w_full  = (r_wr_ptr[LP_AW] != r_rd_ptr[LP_AW]) &&
                   (r_wr_ptr[LP_AW-1:0] == r_rd_ptr[LP_AW-1:0]);
  assign w_empty = (r_wr_ptr == r_rd_ptr);

  assign w_sel_valid = i_ctrl.enable & w_valid[i_ctrl.band];  // Other band ignored
  assign w_push      = w_sel_valid & ~w_full;
  assign w_pop       = i_pop & ~w_empty;

  always_ff @(posedge i_glob_clock) begin
    if (w_push) begin
      r_mem[r_wr_ptr[LP_AW-1:0]] <= w_word[i_ctrl.band];
    end
  end

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_empty  <= 1'b1;
    end else begin
      if (w_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      if (w_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      r_empty <= w_empty;               // Host side sees empty one cycle late
    end
  end

  // ====================================================================
  // Sticky overflow and sync error count
  // ====================================================================
  always_comb begin
    w_err_sum = {1'b0, r_err_count};
    for (int c = 0; c < `MRX_NUM_CH; c++) begin
      w_err_sum = w_err_sum + 9'(w_err[c]);  // Both bands counted
    end
  end

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_ovf       <= 1'b0;
      r_err_count <= 8'h00;
    end else if (i_ovf_clear) begin
      r_ovf       <= 1'b0;
      r_err_count <= 8'h00;
    end else begin
      if (w_sel_valid && w_full) begin
        r_ovf <= 1'b1;                  // Word dropped
      end
      r_err_count <= w_err_sum[8] ? 8'hFF : w_err_sum[7:0];  // Saturate
    end
  end

  assign o_empty     = r_empty;
  assign o_head      = r_mem[r_rd_ptr[LP_AW-1:0]];  // First word fall through
  assign o_status    = {3'b000, w_locked, r_ovf, w_full, r_empty};
  assign o_err_count = r_err_count;

endmodule

//--- lvds_deframer.sv
`timescale 1ns/1ns
`include "modem_rx_settings.svh"

module lvds_deframer import modem_rx_pkg::*; #(
  parameter bit P_INVERT = 1'b0         // Pair wired to the N pin
) (
  input  logic       i_glob_clock,
  input  logic       i_rst_b,
  input  logic [1:0] i_pair,            // DDR bits, first one in bit 1
  deframer_if.source o_df
);

  logic [1:0] w_pair;
  iq_word_u   w_next;
  iq_word_u   r_shift;
  logic       r_busy;                   // Low while hunting for I sync
  logic [3:0] r_pair_cnt;
  logic       r_word_valid;
  logic       r_sync_err;
  logic       r_locked;

  assign w_pair = i_pair ^ {2{P_INVERT}};                         // Polarity fix
  assign w_next.raw = {r_shift.raw[`MRX_WORD_W-3:0], w_pair};     // MSB first

  // ====================================================================
  // Hunt, assemble, check
  // ====================================================================
  always_ff @(posedge i_glob_clock) begin
    r_shift <= w_next;                  // Free running, full frame after pair 16
    if (!i_rst_b) begin
      r_busy       <= 1'b0;
      r_pair_cnt   <= 4'd0;
      r_word_valid <= 1'b0;
      r_sync_err   <= 1'b0;
      r_locked     <= 1'b0;
    end else begin
      r_word_valid <= 1'b0;
      r_sync_err   <= 1'b0;
      if (!r_busy) begin
        if (w_pair == `MRX_I_SYNC) begin
          r_busy     <= 1'b1;           // Pair 1 of 16
          r_pair_cnt <= 4'd1;
          r_locked   <= 1'b1;
        end
      end else begin
        r_pair_cnt <= r_pair_cnt + 4'd1;
        if (r_pair_cnt == 4'd15) begin  // Sixteenth pair arriving now
          r_busy <= 1'b0;               // Next frame may follow back to back
          if (w_next.fields.q_sync == `MRX_Q_SYNC) begin
            r_word_valid <= 1'b1;
          end else begin
            r_sync_err <= 1'b1;
            r_locked   <= 1'b0;         // Misaligned, hunt again
          end
        end
      end
    end
  end

  // Interface drive
  assign o_df.word_valid = r_word_valid;
  assign o_df.word       = r_shift;     // Holds the frame in the strobe cycle
  assign o_df.locked     = r_locked;
  assign o_df.sync_err   = r_sync_err;

endmodule

//--- spi_regs.sv
`timescale 1ns/1ns
`include "modem_rx_settings.svh"

module spi_regs import modem_rx_pkg::*; (
  input  logic       i_glob_clock,
  input  logic       i_rst_b,
  input  logic       i_sck,
  input  logic       i_mosi,
  input  logic       i_ss,
  output logic       o_miso,
  output rx_ctrl_t   o_ctrl,
  output logic       o_ovf_clear,
  input  logic [7:0] i_status,
  input  logic [7:0] i_err_count
);

  logic [2:0]  r_sck_sync;   // Two sync flops plus edge history
  logic [1:0]  r_mosi_sync;
  logic [1:0]  r_ss_sync;
  logic        w_active;
  logic        w_sck_rise;
  logic [3:0]  r_bit_cnt;    // Wraps after 16 bits
  logic [15:0] r_rx;         // {cmd, data}
  logic [15:0] w_rx_next;
  logic [7:0]  r_tx;         // Read shift register
  logic [7:0]  w_rd_data;
  logic        r_wr_pend;
  rx_ctrl_t    r_ctrl;
  logic        r_ovf_clear;

  // ====================================================================
  // Oversampling of the SPI pins
  // ====================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_sck_sync  <= 3'b000;
      r_mosi_sync <= 2'b00;
      r_ss_sync   <= 2'b11;  // Deselected
    end else begin
      r_sck_sync  <= {r_sck_sync[1:0], i_sck};
      r_mosi_sync <= {r_mosi_sync[0], i_mosi};
      r_ss_sync   <= {r_ss_sync[0], i_ss};
    end
  end

  assign w_active   = ~r_ss_sync[1];
  assign w_sck_rise = r_sck_sync[1] & ~r_sck_sync[2] & w_active;  // Mode 0 sample edge
  assign w_rx_next  = {r_rx[14:0], r_mosi_sync[1]};

  // Register read mux, address taken from the byte just completed
  always_comb begin
    case (w_rx_next[4:0])
      `MRX_REG_VERSION: w_rd_data = `MRX_VERSION;
      `MRX_REG_CTRL:    w_rd_data = {6'b000000, r_ctrl};
      `MRX_REG_STATUS:  w_rd_data = i_status;
      `MRX_REG_ERRCNT:  w_rd_data = i_err_count;
      default:          w_rd_data = 8'h00;
    endcase
  end

  // ====================================================================
  // Bit engine and register file
  // ====================================================================
  always_ff @(posedge i_glob_clock) begin
    if (w_sck_rise) begin
      r_rx <= w_rx_next;
    end
    if (!i_rst_b) begin
      r_bit_cnt   <= 4'd0;
      r_tx        <= 8'h00;
      r_wr_pend   <= 1'b0;
      r_ctrl      <= '0;
      r_ovf_clear <= 1'b0;
    end else begin
      r_wr_pend   <= 1'b0;
      r_ovf_clear <= 1'b0;
      if (!w_active) begin
        r_bit_cnt <= 4'd0;                // Realign on every select
      end else if (w_sck_rise) begin
        r_bit_cnt <= r_bit_cnt + 4'd1;
        if (r_bit_cnt == 4'd7) begin
          r_tx <= w_rd_data;              // MSB shows before first data edge
        end else if (r_bit_cnt[3]) begin
          r_tx <= {r_tx[6:0], 1'b0};      // Host already sampled this bit
        end
        if (r_bit_cnt == 4'd15) begin
          r_wr_pend <= w_rx_next[15];     // Write flag of the command byte
        end
      end
      // Applied one cycle after the last bit lands in r_rx
      if (r_wr_pend && (r_rx[12:8] == `MRX_REG_CTRL)) begin
        r_ctrl      <= rx_ctrl_t'(r_rx[1:0]);
        r_ovf_clear <= 1'b1;              // Control write also clears sticky status
      end
    end
  end

  assign o_miso      = r_tx[7] & ~i_ss;   // Quiet while deselected
  assign o_ctrl      = r_ctrl;
  assign o_ovf_clear = r_ovf_clear;

endmodule

//--- deframer_if.sv
`timescale 1ns/1ns

// One deframer to buffer link, no back-pressure
interface deframer_if import modem_rx_pkg::*; ();

  logic     word_valid;  // One-cycle strobe
  iq_word_u word;        // Valid with the strobe only
  logic     locked;      // Level
  logic     sync_err;    // One-cycle strobe on Q sync failure

  modport source (
    output word_valid, word, locked, sync_err
  );

  modport sink (
    input  word_valid, word, locked, sync_err
  );

endinterface

//--- modem_rx_pkg.sv
`include "modem_rx_settings.svh"

package modem_rx_pkg;

  // Frame layout on the wire, MSB first
  typedef struct packed {
    logic [1:0]  i_sync;   // Must be 2'b10
    logic [13:0] i_data;
    logic [1:0]  q_sync;   // Must be 2'b01
    logic [13:0] q_data;
  } iq_fields_t;

  // Same 32 bits, stored word or decoded frame
  typedef union packed {
    logic [`MRX_WORD_W-1:0] raw;
    iq_fields_t             fields;
  } iq_word_u;

  typedef enum logic {
    BAND_09 = 1'b0,
    BAND_24 = 1'b1
  } band_t;

  // Control register, byte bits [1:0]
  typedef struct packed {
    logic  enable;   // Bit 1
    band_t band;     // Bit 0
  } rx_ctrl_t;

endpackage

//--- modem_rx_settings.svh
`ifndef MODEM_RX_SETTINGS_SVH
`define MODEM_RX_SETTINGS_SVH

// Band channels, index 0 is 900 MHz, index 1 is 2.4 GHz
`define MRX_NUM_CH       2
`define MRX_WORD_W       32          // One I/Q frame
`define MRX_FIFO_DEPTH   16          // Sample FIFO, power of two
`define MRX_INVERT_MASK  2'b10       // 2.4 GHz pair lands on the N pin

// Frame sync patterns
`define MRX_I_SYNC       2'b10
`define MRX_Q_SYNC       2'b01

// Host register map
`define MRX_VERSION      8'h5A
`define MRX_REG_VERSION  5'd0
`define MRX_REG_CTRL     5'd1
`define MRX_REG_STATUS   5'd2
`define MRX_REG_ERRCNT   5'd3

`endif
